// File: compile.f
hdl/icache_pkg.sv
hdl/icache_way_ram.sv
hdl/icache_plru.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_pipe.sv
hdl/icache_top.sv
sim/axi_mem_model.sv
sim/icache_tb.sv

// File: hdl/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  stage_t       tag_stage,
    input  stage_t       data_stage,
    input  set_idx_t     next_set,
    input  logic         hit,
    input  logic         burst_done,
    input  way_sel_t     victim,
    input  cache_tag_t   fill_tag,
    output cache_state_e state,
    output array_cmd_t   cmd,
    output logic         plru_pick,
    output logic         plru_commit
);

    cache_state_e state_nxt;
    set_idx_t     sweep_cnt;
    logic         need_fill;

    // data stage lookup failed in run
    assign need_fill = (state == run) && data_stage.valid
                    && !data_stage.exception && !hit;

    assign plru_pick   = need_fill;
    assign plru_commit = (state == finish);

    ////////////////////
    // main FSM
    ////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            reset_sweep: begin
                if (sweep_cnt == set_idx_t'(reset_sweep_last)) begin
                    state_nxt = idle;
                end
            end
            idle:    state_nxt = run;
            run:     state_nxt = need_fill ? miss : run;
            miss:    state_nxt = burst_done ? refill : miss;
            refill:  state_nxt = burst_done ? finish : refill;
            finish:  state_nxt = recover;
            // re-read the filled set, then compare it in idle
            recover: state_nxt = idle;
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= reset_sweep;
            sweep_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == reset_sweep) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // array command
    ////////////////////
    always_comb begin
        cmd = '0;
        case (state)
            reset_sweep: begin
                cmd.set  = sweep_cnt;
                cmd.wway = '1;
            end
            finish: begin
                cmd.set      = data_stage.set;
                cmd.wway     = victim;
                cmd.wtag     = fill_tag;
                cmd.wvalid   = 1'b1;
                cmd.wline_en = 1'b1;
            end
            idle:    cmd.set = tag_stage.set;
            run:     cmd.set = next_set;
            default: cmd.set = data_stage.set;
        endcase
    end

endmodule

// File: hdl/icache_pipe.sv
`timescale 1ns/1ns

module icache_pipe
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // CPU request
    input  logic         req,
    input  logic [7:0]   index,
    input  cache_tag_t   tag,
    input  logic         exception,
    input  cache_state_e state,
    // way array outputs
    input  cache_tag_t   way_tag [num_ways],
    input  way_sel_t     way_valid,
    input  line_t        way_line [num_ways],
    output logic         index_ok,
    output logic         data_ok,
    output half_line_t   rdata,
    output stage_t       tag_stage,
    output stage_t       data_stage,
    output set_idx_t     next_set,
    output logic         hit
);

    stage_t     ts_q;
    logic       ts_fresh;
    stage_t     ds_q;
    way_sel_t   hit_way_q;
    half_line_t half_q;
    logic       advance;

    cache_tag_t cmp_tag;
    logic       cmp_off;
    way_sel_t   hit_now;
    line_t      sel_line;
    half_line_t half_now;

    ////////////////////
    // CPU strobes
    ////////////////////
    assign hit      = |hit_way_q;
    assign data_ok  = ds_q.valid && ((hit && (state == run)) || ds_q.exception);
    assign advance  = (state == run) && (!ds_q.valid || data_ok);
    assign index_ok = (state == run) && req && (!ds_q.valid || data_ok);
    assign rdata    = half_q;

    // array read target for the next cycle
    assign next_set = index_ok ? index[7:1] : tag_stage.set;

    // tag and exception arrive one cycle after the index
    always_comb begin
        tag_stage = ts_q;
        if (ts_fresh) begin
            tag_stage.tag       = tag;
            tag_stage.exception = exception;
        end
    end

    assign data_stage = ds_q;

    ////////////////////
    // hit compare
    ////////////////////
    // idle re-checks the data stage against the refilled set
    always_comb begin
        cmp_tag  = (state == idle) ? ds_q.tag : tag_stage.tag;
        cmp_off  = (state == idle) ? ds_q.offset : tag_stage.offset;
        hit_now  = '0;
        sel_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_now[w] = way_valid[w] && (way_tag[w] == cmp_tag);
            if (hit_now[w]) begin
                sel_line = sel_line | way_line[w];
            end
        end
        half_now = cmp_off ? sel_line[255:128] : sel_line[127:0];
    end

    ////////////////////
    // stage registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            ts_q.valid <= 1'b0;
            ts_fresh   <= 1'b0;
        end else begin
            ts_fresh <= index_ok;
            if (index_ok) begin
                ts_q.valid  <= 1'b1;
                ts_q.set    <= index[7:1];
                ts_q.offset <= index[0];
            end else if (advance) begin
                ts_q.valid <= 1'b0;
            end
            // keep the late fields while the stage is held
            if (ts_fresh) begin
                ts_q.tag       <= tag;
                ts_q.exception <= exception;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ds_q.valid <= 1'b0;
            hit_way_q  <= '0;
        end else if (advance) begin
            ds_q      <= tag_stage;
            hit_way_q <= hit_now;
        end else if (state == idle) begin
            hit_way_q <= hit_now;
        end
    end

    always_ff @(posedge clk) begin
        if (advance || (state == idle)) begin
            half_q <= half_now;
        end
    end

endmodule

// File: hdl/icache_pkg.sv
package icache_pkg;

    ////////////////////
    // geometry
    ////////////////////
    localparam int num_ways         = 4;
    localparam int num_sets         = 128;
    localparam int words_per_line   = 8;
    // last set cleared by the sweep after reset
    localparam int reset_sweep_last = 127;

    ////////////////////
    // vector types
    ////////////////////
    typedef logic [6:0]   set_idx_t;
    typedef logic [19:0]  cache_tag_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] half_line_t;
    typedef logic [255:0] line_t;
    typedef logic [3:0]   way_sel_t;
    typedef logic [2:0]   plru_bits_t;
    typedef logic [2:0]   beat_idx_t;

    // one request as it moves down the pipeline
    typedef struct packed {
        logic       valid;
        set_idx_t   set;
        logic       offset;
        cache_tag_t tag;
        logic       exception;
    } stage_t;

    // shared access to the four way arrays
    typedef struct packed {
        set_idx_t   set;
        way_sel_t   wway;
        cache_tag_t wtag;
        logic       wvalid;
        // line data is written only on a fill
        logic       wline_en;
    } array_cmd_t;

    typedef enum logic [2:0] {
        reset_sweep,
        idle,
        run,
        miss,
        refill,
        finish,
        recover
    } cache_state_e;

endpackage

// File: hdl/icache_plru.sv
`timescale 1ns/1ns

module icache_plru
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t set,
    input  logic     pick,
    input  logic     commit,
    output way_sel_t victim
);

    plru_bits_t tree [num_sets];
    plru_bits_t cur;
    way_sel_t   pick_way;

    assign cur = tree[set];

    // bit 0 picks the pair, bit 1 or bit 2 the way inside it
    always_comb begin
        if (!cur[0]) begin
            pick_way = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            pick_way = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= 4'b0001;
            for (int i = 0; i < num_sets; i++) begin
                tree[i] <= '0;
            end
        end else begin
            if (pick) begin
                victim <= pick_way;
            end
            // turn the tree away from the way just filled
            if (commit) begin
                case (victim)
                    4'b0001: tree[set] <= {cur[2], 2'b11};
                    4'b0010: tree[set] <= {cur[2], 2'b01};
                    4'b0100: tree[set] <= {1'b1, cur[1], 1'b0};
                    4'b1000: tree[set] <= {1'b0, cur[1], 1'b0};
                    default: tree[set] <= cur;
                endcase
            end
        end
    end

endmodule

// File: hdl/icache_refill.sv
`timescale 1ns/1ns

module icache_refill
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cache_state_e state,
    input  stage_t       miss_req,
    // AXI read address
    output logic [31:0]  araddr,
    output logic         arvalid,
    input  logic         arready,
    // AXI read data
    input  word_t        rdata,
    input  logic         rvalid,
    input  logic         rlast,
    output logic         rready,
    output line_t        fill_line,
    output logic         burst_done
);

    word_t     line_buf [words_per_line];
    beat_idx_t beat;
    logic      beat_take;

    ////////////////////
    // address channel
    ////////////////////
    // requested half line first, the slave wraps inside the line
    assign araddr  = {miss_req.tag, miss_req.set, miss_req.offset, 4'b0000};
    assign arvalid = (state == miss);
    assign rready  = (state == refill);

    // ends the current bus phase
    // address taken in miss, last beat in refill
    assign burst_done = ((state == miss) && arready)
                     || ((state == refill) && rvalid && rlast);

    ////////////////////
    // data channel
    ////////////////////
    assign beat_take = rvalid && rready;

    // counter wraps on its own at 3 bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            beat <= '0;
        end else if (state == miss) begin
            beat <= {miss_req.offset, 2'b00};
        end else if (beat_take) begin
            beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            line_buf[beat] <= rdata;
        end
    end

    // word 0 in the low bits of the line
    always_comb begin
        for (int i = 0; i < words_per_line; i++) begin
            fill_line[i*32 +: 32] = line_buf[i];
        end
    end

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // CPU side
    input  logic        req,
    input  logic [7:0]  index,
    input  cache_tag_t  tag,
    input  logic        exception,
    output logic        index_ok,
    output logic        data_ok,
    output half_line_t  inst_rdata,
    // AXI read side
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  word_t       rdata,
    input  logic        rvalid,
    input  logic        rlast,
    output logic        rready
);

    stage_t       tag_stage;
    stage_t       data_stage;
    set_idx_t     next_set;
    logic         hit;
    cache_state_e state;
    array_cmd_t   cmd;
    logic         plru_pick;
    logic         plru_commit;
    way_sel_t     victim;
    line_t        fill_line;
    logic         burst_done;

    cache_tag_t   way_tag  [num_ways];
    way_sel_t     way_valid;
    line_t        way_line [num_ways];

    icache_pipe u_pipe (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .index      (index),
        .tag        (tag),
        .exception  (exception),
        .state      (state),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_line   (way_line),
        .index_ok   (index_ok),
        .data_ok    (data_ok),
        .rdata      (inst_rdata),
        .tag_stage  (tag_stage),
        .data_stage (data_stage),
        .next_set   (next_set),
        .hit        (hit)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .tag_stage   (tag_stage),
        .data_stage  (data_stage),
        .next_set    (next_set),
        .hit         (hit),
        .burst_done  (burst_done),
        .victim      (victim),
        .fill_tag    (data_stage.tag),
        .state       (state),
        .cmd         (cmd),
        .plru_pick   (plru_pick),
        .plru_commit (plru_commit)
    );

    icache_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .miss_req   (data_stage),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rready     (rready),
        .fill_line  (fill_line),
        .burst_done (burst_done)
    );

    icache_plru u_plru (
        .clk    (clk),
        .rst    (rst),
        .set    (data_stage.set),
        .pick   (plru_pick),
        .commit (plru_commit),
        .victim (victim)
    );

    // one array per way, all driven by the same command
    for (genvar k = 0; k < num_ways; k++) begin : g_way
        icache_way_ram u_way_ram (
            .clk     (clk),
            .cmd     (cmd),
            .way_bit (cmd.wway[k]),
            .tag_q   (way_tag[k]),
            .valid_q (way_valid[k]),
            .line_q  (way_line[k]),
            .wline   (fill_line)
        );
    end

endmodule

// File: hdl/icache_way_ram.sv
`timescale 1ns/1ns

module icache_way_ram
    import icache_pkg::*;
(
    input  logic       clk,
    input  array_cmd_t cmd,
    input  logic       way_bit,
    output cache_tag_t tag_q,
    output logic       valid_q,
    output line_t      line_q,
    input  line_t      wline
);

    cache_tag_t tag_mem   [num_sets];
    logic       valid_mem [num_sets];
    line_t      line_mem  [num_sets];

    // write port, tag and valid always go together
    always_ff @(posedge clk) begin
        if (way_bit) begin
            tag_mem[cmd.set]   <= cmd.wtag;
            valid_mem[cmd.set] <= cmd.wvalid;
            if (cmd.wline_en) begin
                line_mem[cmd.set] <= wline;
            end
        end
    end

    // registered read, one cycle after the set is presented
    always_ff @(posedge clk) begin
        tag_q   <= tag_mem[cmd.set];
        valid_q <= valid_mem[cmd.set];
        line_q  <= line_mem[cmd.set];
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module icache_tb -f compile.f -o icache_sim

out=$(./obj_dir/icache_sim)
printf '%s\n' "$out"

# exit status follows the search for the pass line
printf '%s\n' "$out" | grep -q "Finished with no errors"

// File: sim/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    output logic        rlast,
    input  logic        rready,
    output int          ar_count
);

    logic        busy;
    logic [26:0] line_base;
    beat_idx_t   first;
    beat_idx_t   beat;
    beat_idx_t   word_pos;

    // word index rolls over inside the 32-byte line
    assign word_pos = first + beat;
    assign rdata    = {line_base, word_pos, 2'b00} ^ 32'h5a5a_a5a5;
    assign rvalid   = busy;
    assign rlast    = busy && (beat == 3'd7);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b0;
            arready   <= 1'b0;
            beat      <= '0;
            first     <= '0;
            line_base <= '0;
            ar_count  <= 0;
        end else begin
            // address taken one cycle after arvalid rises
            arready <= arvalid && !arready && !busy;
            if (arvalid && arready) begin
                busy      <= 1'b1;
                line_base <= araddr[31:5];
                first     <= araddr[4:2];
                beat      <= '0;
                ar_count  <= ar_count + 1;
            end else if (busy && rready) begin
                beat <= beat + 1'b1;
                if (beat == 3'd7) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: sim/icache_tb.sv
`timescale 1ns/1ns

module icache_tb
    import icache_pkg::*;
();

    localparam int stream_len = 40;
    // fifteen directed requests plus the random stream
    localparam int total_reqs = 15 + stream_len;

    logic        clk;
    logic        rst;
    logic        req;
    logic [7:0]  index;
    cache_tag_t  tag;
    logic        exception;
    logic        index_ok;
    logic        data_ok;
    half_line_t  inst_rdata;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic        rvalid;
    logic        rlast;
    logic        rready;
    int          ar_count;

    stage_t      pending [$];
    stage_t      next_req;
    stage_t      done_req;
    stage_t      miss_req;
    int          accept_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    // lines known to be resident before the stream
    cache_tag_t  res_tag [8];
    set_idx_t    res_set [8];

    icache_top u_icache_top (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .index      (index),
        .tag        (tag),
        .exception  (exception),
        .index_ok   (index_ok),
        .data_ok    (data_ok),
        .inst_rdata (inst_rdata),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rready     (rready)
    );

    axi_mem_model u_mem (
        .clk      (clk),
        .rst      (rst),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rlast    (rlast),
        .rready   (rready),
        .ar_count (ar_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // reference and checks
    ////////////////////
    // memory word is its byte address xor a fixed pattern
    function automatic half_line_t ref_half(cache_tag_t t, set_idx_t s, logic off);
        half_line_t  h;
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = {t, s, off, 2'(i), 2'b00};
            h[i*32 +: 32] = addr ^ 32'h5a5a_a5a5;
        end
        return h;
    endfunction

    task automatic check_half(string name, half_line_t got, half_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // pops the oldest request on data_ok and queues new ones on acceptance
    always @(posedge clk) begin
        // a burst always serves the oldest outstanding request
        if (rst && arvalid && arready) begin
            if (pending.size() == 0) begin
                errors++;
                $display("read burst issued with no request outstanding");
            end else begin
                miss_req = pending[0];
                check_addr("araddr", araddr,
                           {miss_req.tag, miss_req.set, miss_req.offset, 4'b0000});
            end
        end
        if (rst && data_ok) begin
            if (pending.size() == 0) begin
                errors++;
                $display("data_ok pulsed with no request outstanding");
            end else begin
                done_req = pending.pop_front();
                if (!done_req.exception) begin
                    check_half("inst_rdata", inst_rdata,
                               ref_half(done_req.tag, done_req.set, done_req.offset));
                end
            end
        end
        if (rst && req && index_ok) begin
            pending.push_back(next_req);
            accept_cnt <= accept_cnt + 1;
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    // entered on a falling edge with the tag driven in the cycle after acceptance
    task automatic issue(cache_tag_t t, set_idx_t s, logic off, logic exc);
        int mark;
        mark = accept_cnt;
        next_req.valid     = 1'b1;
        next_req.set       = s;
        next_req.offset    = off;
        next_req.tag       = t;
        next_req.exception = exc;
        req   = 1'b1;
        index = {s, off};
        while (accept_cnt == mark) begin
            @(negedge clk);
        end
        req       = 1'b0;
        tag       = t;
        exception = exc;
    endtask

    task automatic drain();
        while (pending.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(int num, string name, int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
        end
    endtask

    initial begin
        repeat (total_reqs * 200 + num_sets + 16) @(posedge clk);
        $display("watchdog expired with %0d requests still outstanding", pending.size());
        $display("Finished with errors");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        int err_mark;
        int ar_mark;
        int pick;
        void'($urandom(32'h63));
        rst       = 1'b0;
        req       = 1'b0;
        index     = '0;
        tag       = '0;
        exception = 1'b0;
        next_req  = '0;

        // reset and sweep
        err_mark = errors;
        repeat (7) @(negedge clk);
        check_bit("index_ok", index_ok, 1'b0);
        check_bit("data_ok", data_ok, 1'b0);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        @(negedge clk);
        rst   = 1'b1;
        req   = 1'b1;
        index = {7'h03, 1'b0};
        // sweep cycles 1 to 127 and then idle
        repeat (128) begin
            @(negedge clk);
            check_bit("index_ok", index_ok, 1'b0);
        end
        // first run cycle takes the waiting request
        @(negedge clk);
        check_bit("index_ok", index_ok, 1'b1);
        issue(20'h0abcd, 7'h03, 1'b0, 1'b0);
        drain();
        check_count("ar_count", ar_count, 1);
        report_test(1, "reset", err_mark);

        err_mark = errors;
        ar_mark  = ar_count;
        issue(20'h12345, 7'h10, 1'b0, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 1);
        issue(20'h12345, 7'h10, 1'b0, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 1);
        report_test(2, "miss then hit", err_mark);

        // one line filled from the high half and one from the low half
        err_mark = errors;
        ar_mark  = ar_count;
        issue(20'h2468a, 7'h21, 1'b1, 1'b0);
        drain();
        issue(20'h2468a, 7'h21, 1'b0, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 1);
        issue(20'h13579, 7'h22, 1'b0, 1'b0);
        drain();
        issue(20'h13579, 7'h22, 1'b1, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 2);
        report_test(3, "both halves", err_mark);

        // fills go to ways 0, 2, 1 and 3 and the fifth evicts the first tag
        err_mark = errors;
        ar_mark  = ar_count;
        for (int k = 0; k < 5; k++) begin
            issue(cache_tag_t'(32'h40000 + k), 7'h55, 1'b0, 1'b0);
            drain();
        end
        check_count("ar_count", ar_count, ar_mark + 5);
        issue(20'h40001, 7'h55, 1'b1, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 5);
        issue(20'h40000, 7'h55, 1'b0, 1'b0);
        drain();
        check_count("ar_count", ar_count, ar_mark + 6);
        report_test(4, "replacement", err_mark);

        err_mark = errors;
        ar_mark  = ar_count;
        issue(20'h77777, 7'h70, 1'b0, 1'b1);
        drain();
        check_count("ar_count", ar_count, ar_mark);
        report_test(5, "exception", err_mark);

        // second tag of set 0x55 was the victim of the last refill
        res_tag = '{20'h0abcd, 20'h12345, 20'h2468a, 20'h13579,
                    20'h40000, 20'h40002, 20'h40003, 20'h40004};
        res_set = '{7'h03, 7'h10, 7'h21, 7'h22, 7'h55, 7'h55, 7'h55, 7'h55};
        err_mark = errors;
        ar_mark  = ar_count;
        for (int k = 0; k < stream_len; k++) begin
            pick = $urandom_range(7, 0);
            issue(res_tag[pick], res_set[pick], 1'($urandom()), 1'b0);
        end
        drain();
        check_count("ar_count", ar_count, ar_mark);
        report_test(6, "streaming", err_mark);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
